/* common/zxuno_pkg.sv */
`default_nettype none

package zxuno_pkg;

   // ----------------------------------------
   // I/O ports of the register bus
   // ----------------------------------------
   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

   // Register numbers behind the data port
   localparam logic [7:0] REG_RASTERLINE = 8'h0C;
   localparam logic [7:0] REG_RASTERCTRL = 8'h0D;
   localparam logic [7:0] REG_DEVOPTIONS = 8'h0E;
   localparam logic [7:0] REG_SCRATCH    = 8'hFE;
   localparam logic [7:0] REG_COREID     = 8'hFF;

   // ----------------------------------------
   // Core identification and bus constants
   // ----------------------------------------
   localparam logic [7:0] COREID_LEN = 8'd8;

   // First character sits in the top byte
   localparam logic [COREID_LEN*8-1:0] COREID_STRING = "ZXUNOREG";

   // Value seen by the CPU when nothing drives the bus
   localparam logic [7:0] FLOATING_BUS = 8'hFF;

   // ----------------------------------------
   // Shared structs
   // ----------------------------------------
   typedef struct packed {
      logic [15:0] addr;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
   } z80_io_t;

   typedef struct packed {
      logic [7:0] reg_addr;
      logic       reg_rd;
      logic       reg_wr;
      logic       regaddr_changed;
   } zxreg_access_t;

   typedef struct packed {
      logic       oe_n;
      logic [7:0] data;
   } read_src_t;

   // Bit 7 first, bit 0 last
   typedef struct packed {
      logic disable_spisd;
      logic enable_timexmmu;
      logic disable_romsel1f;
      logic disable_romsel7f;
      logic disable_1ffd;
      logic disable_7ffd;
      logic disable_turboay;
      logic disable_ay;
   } dev_options_t;

   typedef struct packed {
      logic [8:0] raster_line;
      logic       rasterint_enable;
      logic       vretraceint_disable;
   } raster_cfg_t;

endpackage

`default_nettype wire

/* zxregs/zxuno_addr_port.sv */
`timescale 1ns/10ps
`default_nettype none

module zxuno_addr_port import zxuno_pkg::*; (
   input  wire logic          cpuclkplain,
   input  wire logic          rst_n,
   input  wire z80_io_t       io,
   input  wire logic [7:0]    cpu_dout,
   output      zxreg_access_t acc,
   output      read_src_t     addr_src
);

   logic       io_rd;
   logic       io_wr;
   logic       addr_sel;
   logic       data_sel;
   logic [7:0] reg_addr_q;
   logic       changed_q;

   // ----------------------------------------
   // Port decode
   // ----------------------------------------
   assign io_rd    = !io.iorq_n && !io.rd_n;
   assign io_wr    = !io.iorq_n && !io.wr_n;
   assign addr_sel = (io.addr == ZXUNO_ADDR_PORT);
   assign data_sel = (io.addr == ZXUNO_DATA_PORT);

   // Register address, plus a pulse after every write to it
   always_ff @(posedge cpuclkplain or negedge rst_n) begin
      if (!rst_n) begin
         reg_addr_q <= 8'h00;
         changed_q  <= 1'b0;
      end else begin
         changed_q <= addr_sel && io_wr;
         if (addr_sel && io_wr) begin
            reg_addr_q <= cpu_dout;
         end
      end
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------
   assign acc.reg_addr        = reg_addr_q;
   assign acc.reg_rd          = data_sel && io_rd;
   assign acc.reg_wr          = data_sel && io_wr;
   assign acc.regaddr_changed = changed_q;

   // Address readback through FC3B
   assign addr_src.oe_n = !(addr_sel && io_rd);
   assign addr_src.data = reg_addr_q;

endmodule

`default_nettype wire

/* zxregs/coreid_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module coreid_reader import zxuno_pkg::*; (
   input  wire logic          cpuclkplain,
   input  wire logic          rst_n,
   input  wire zxreg_access_t acc,
   output      read_src_t     coreid_src
);

   logic                      id_rd;
   logic                      id_rd_q;
   logic [7:0]                idx_q;
   logic [COREID_LEN*8-1:0]   id_shifted;

   assign id_rd = acc.reg_rd && (acc.reg_addr == REG_COREID);

   // Index moves on the falling end of a read, so a long access counts once
   always_ff @(posedge cpuclkplain or negedge rst_n) begin
      if (!rst_n) begin
         id_rd_q <= 1'b0;
         idx_q   <= 8'h00;
      end else begin
         id_rd_q <= id_rd;
         if (acc.regaddr_changed) begin
            idx_q <= 8'h00;
         end else if (id_rd_q && !id_rd && (idx_q != COREID_LEN)) begin
            idx_q <= idx_q + 8'd1;
         end
      end
   end

   // Current character ends up in the top byte
   // Past the end of the string the shift leaves zeros
   assign id_shifted = COREID_STRING << {idx_q, 3'b000};

   assign coreid_src.oe_n = !id_rd;
   assign coreid_src.data = id_shifted[COREID_LEN*8-1 -: 8];

endmodule

`default_nettype wire

/* zxregs/option_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module option_regs import zxuno_pkg::*; (
   input  wire logic          cpuclkplain,
   input  wire logic          rst_n,
   input  wire zxreg_access_t acc,
   input  wire logic [7:0]    cpu_dout,
   output      dev_options_t  dev_options,
   output      read_src_t     opt_src
);

   logic [7:0]   scratch_q;
   dev_options_t devopt_q;

   // Scratch byte, free for software use
   always_ff @(posedge cpuclkplain) begin
      if (acc.reg_wr && (acc.reg_addr == REG_SCRATCH)) begin
         scratch_q <= cpu_dout;
      end
   end

   // Device options, all bits cleared by reset
   always_ff @(posedge cpuclkplain or negedge rst_n) begin
      if (!rst_n) begin
         devopt_q <= '0;
      end else if (acc.reg_wr && (acc.reg_addr == REG_DEVOPTIONS)) begin
         devopt_q <= cpu_dout;
      end
   end

   assign dev_options = devopt_q;

   // Readback of whichever register is addressed
   always_comb begin
      opt_src.oe_n = 1'b1;
      opt_src.data = devopt_q;
      if (acc.reg_rd && (acc.reg_addr == REG_SCRATCH)) begin
         opt_src.oe_n = 1'b0;
         opt_src.data = scratch_q;
      end else if (acc.reg_rd && (acc.reg_addr == REG_DEVOPTIONS)) begin
         opt_src.oe_n = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* zxregs/rasterint_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module rasterint_ctrl import zxuno_pkg::*; (
   input  wire logic          cpuclkplain,
   input  wire logic          rst_n,
   input  wire zxreg_access_t acc,
   input  wire logic [7:0]    cpu_dout,
   input  wire logic          raster_int_in_progress,
   output      raster_cfg_t   raster_cfg,
   output      read_src_t     raster_src
);

   raster_cfg_t cfg_q;
   logic        line_sel;
   logic        ctrl_sel;

   assign line_sel = (acc.reg_addr == REG_RASTERLINE);
   assign ctrl_sel = (acc.reg_addr == REG_RASTERCTRL);

   // ----------------------------------------
   // Configuration registers
   // ----------------------------------------
   always_ff @(posedge cpuclkplain or negedge rst_n) begin
      if (!rst_n) begin
         cfg_q <= '0;
      end else if (acc.reg_wr && line_sel) begin
         cfg_q.raster_line[7:0] <= cpu_dout;
      end else if (acc.reg_wr && ctrl_sel) begin
         // Line bit 8 lives in the control register
         cfg_q.raster_line[8]      <= cpu_dout[0];
         cfg_q.rasterint_enable    <= cpu_dout[1];
         cfg_q.vretraceint_disable <= cpu_dout[2];
      end
   end

   assign raster_cfg = cfg_q;

   // ----------------------------------------
   // Readback
   // ----------------------------------------
   always_comb begin
      raster_src.oe_n = !(acc.reg_rd && (line_sel || ctrl_sel));
      if (ctrl_sel) begin
         raster_src.data = {4'b0000, raster_int_in_progress, cfg_q.vretraceint_disable,
                            cfg_q.rasterint_enable, cfg_q.raster_line[8]};
      end else begin
         raster_src.data = cfg_q.raster_line[7:0];
      end
   end

endmodule

`default_nettype wire

/* src/cpu_read_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_read_mux import zxuno_pkg::*; (
   input  wire read_src_t addr_src,
   input  wire read_src_t coreid_src,
   input  wire read_src_t opt_src,
   input  wire read_src_t raster_src,
   output      logic [7:0] cpu_din
);

   // First active source wins, address port highest
   always_comb begin
      if (!addr_src.oe_n) begin
         cpu_din = addr_src.data;
      end else if (!coreid_src.oe_n) begin
         cpu_din = coreid_src.data;
      end else if (!opt_src.oe_n) begin
         cpu_din = opt_src.data;
      end else if (!raster_src.oe_n) begin
         cpu_din = raster_src.data;
      end else begin
         cpu_din = FLOATING_BUS;
      end
   end

endmodule

`default_nettype wire

/* src/zxuno_core.sv */
`timescale 1ns/10ps
`default_nettype none

module zxuno_core import zxuno_pkg::*; (
   input  wire logic         cpuclkplain,
   input  wire logic         rst_n,
   input  wire z80_io_t      io,
   input  wire logic [7:0]   cpu_dout,
   input  wire logic         raster_int_in_progress,
   output      logic [7:0]   cpu_din,
   output      dev_options_t dev_options,
   output      raster_cfg_t  raster_cfg
);

   // Decoded register access shared by all register blocks
   zxreg_access_t acc;

   // One read source per block
   read_src_t addr_src;
   read_src_t coreid_src;
   read_src_t opt_src;
   read_src_t raster_src;

   zxuno_addr_port addr_port_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .io          (io),
      .cpu_dout    (cpu_dout),
      .acc         (acc),
      .addr_src    (addr_src)
   );

   coreid_reader coreid_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .acc         (acc),
      .coreid_src  (coreid_src)
   );

   option_regs options_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .acc         (acc),
      .cpu_dout    (cpu_dout),
      .dev_options (dev_options),
      .opt_src     (opt_src)
   );

   rasterint_ctrl rasterint_i (
      .cpuclkplain            (cpuclkplain),
      .rst_n                  (rst_n),
      .acc                    (acc),
      .cpu_dout               (cpu_dout),
      .raster_int_in_progress (raster_int_in_progress),
      .raster_cfg             (raster_cfg),
      .raster_src             (raster_src)
   );

   cpu_read_mux read_mux_i (
      .addr_src   (addr_src),
      .coreid_src (coreid_src),
      .opt_src    (opt_src),
      .raster_src (raster_src),
      .cpu_din    (cpu_din)
   );

endmodule

`default_nettype wire

/* bench/zxuno_core_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module zxuno_core_properties import zxuno_pkg::*; (
   input wire logic          cpuclkplain,
   input wire logic          rst_n,
   input wire z80_io_t       io,
   input wire logic [7:0]    cpu_dout,
   input wire logic [7:0]    cpu_din,
   input wire dev_options_t  dev_options,
   input wire raster_cfg_t   raster_cfg,
   input wire zxreg_access_t acc
);

   logic io_rd;
   logic addr_wr;

   assign io_rd   = !io.iorq_n && !io.rd_n;
   assign addr_wr = !io.iorq_n && !io.wr_n && (io.addr == ZXUNO_ADDR_PORT);

   // Bus floats outside I/O reads
   floating_idle: assert property (@(posedge cpuclkplain) disable iff (!rst_n)
      !io_rd |-> (cpu_din == FLOATING_BUS))
      else $error("cpu_din driven outside an I/O read");

   outputs_in_reset: assert property (@(posedge cpuclkplain)
      !rst_n |-> (dev_options == '0 && raster_cfg == '0))
      else $error("dev_options or raster_cfg nonzero in reset");

   // Register address capture and change pulse
   addr_capture: assert property (@(posedge cpuclkplain) disable iff (!rst_n)
      addr_wr |=> (acc.reg_addr == $past(cpu_dout) && acc.regaddr_changed))
      else $error("register address write not captured");

endmodule

bind zxuno_core zxuno_core_properties props_i (
   .cpuclkplain (cpuclkplain),
   .rst_n       (rst_n),
   .io          (io),
   .cpu_dout    (cpu_dout),
   .cpu_din     (cpu_din),
   .dev_options (dev_options),
   .raster_cfg  (raster_cfg),
   .acc         (acc)
);

`default_nettype wire

/* bench/zxuno_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module zxuno_core_tb import zxuno_pkg::*; ();

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_MEM} op_kind_t;

   // For reads, data bit 0 is the raster_int_in_progress level
   typedef struct packed {
      op_kind_t    kind;
      logic [15:0] port;
      logic [7:0]  data;
      logic [7:0]  exp;
   } op_t;

   logic         cpuclkplain;
   logic         rst_n;
   z80_io_t      io;
   logic [7:0]   cpu_dout;
   logic         raster_int_in_progress;
   logic [7:0]   cpu_din;
   dev_options_t dev_options;
   raster_cfg_t  raster_cfg;

   op_t          ops[$];
   int           cycle_count = 0;
   int           cycle_limit = 0;
   logic [7:0]   trk_reg;
   dev_options_t exp_dev;
   raster_cfg_t  exp_raster;

   zxuno_core dut_i (
      .cpuclkplain            (cpuclkplain),
      .rst_n                  (rst_n),
      .io                     (io),
      .cpu_dout               (cpu_dout),
      .raster_int_in_progress (raster_int_in_progress),
      .cpu_din                (cpu_din),
      .dev_options            (dev_options),
      .raster_cfg             (raster_cfg)
   );

   initial begin
      cpuclkplain = 1'b0;
      forever #5 cpuclkplain = ~cpuclkplain;
   end

   always @(posedge cpuclkplain) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAIL");
         $fatal(1, "Run stopped by the cycle counter");
      end
   end

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic add_op(input op_kind_t kind, input logic [15:0] port,
                         input logic [7:0] data, input logic [7:0] exp);
      op_t op;
      op = {kind, port, data, exp};
      ops.push_back(op);
   endtask

   task automatic write_reg(input logic [7:0] num, input logic [7:0] val);
      add_op(OP_WR, ZXUNO_ADDR_PORT, num, 8'h00);
      add_op(OP_WR, ZXUNO_DATA_PORT, val, 8'h00);
   endtask

   task automatic read_reg(input logic [7:0] num, input logic [7:0] exp, input logic rint);
      add_op(OP_WR, ZXUNO_ADDR_PORT, num, 8'h00);
      add_op(OP_RD, ZXUNO_DATA_PORT, {7'd0, rint}, exp);
   endtask

   // ----------------------------------------
   // Stimulus table
   // ----------------------------------------
   task automatic build_ops();
      logic [7:0] r;
      logic [7:0] id_byte;
      int         id_len;
      id_len = int'(COREID_LEN);
      // Reset value, then address port readback
      add_op(OP_RD, ZXUNO_ADDR_PORT, 8'h00, 8'h00);
      add_op(OP_WR, ZXUNO_ADDR_PORT, 8'h5A, 8'h00);
      add_op(OP_RD, ZXUNO_ADDR_PORT, 8'h00, 8'h5A);
      for (int i = 0; i < 4; i++) begin
         r = 8'($urandom);
         write_reg(REG_SCRATCH, r);
         read_reg(REG_SCRATCH, r, 1'b0);
      end
      write_reg(REG_DEVOPTIONS, 8'hA5);
      read_reg(REG_DEVOPTIONS, 8'hA5, 1'b0);
      write_reg(REG_DEVOPTIONS, 8'h3C);
      read_reg(REG_DEVOPTIONS, 8'h3C, 1'b0);
      // Raster line 0x1A7 with the interrupt enabled
      write_reg(REG_RASTERLINE, 8'hA7);
      write_reg(REG_RASTERCTRL, 8'h03);
      read_reg(REG_RASTERLINE, 8'hA7, 1'b0);
      read_reg(REG_RASTERCTRL, 8'h03, 1'b0);
      read_reg(REG_RASTERCTRL, 8'h0B, 1'b1);
      write_reg(REG_RASTERCTRL, 8'hFC);
      read_reg(REG_RASTERCTRL, 8'h0C, 1'b1);
      // Core ID string, then zeros past the end
      add_op(OP_WR, ZXUNO_ADDR_PORT, REG_COREID, 8'h00);
      for (int i = 0; i < id_len + 2; i++) begin
         id_byte = (i < id_len) ? COREID_STRING[(id_len - 1 - i) * 8 +: 8] : 8'h00;
         add_op(OP_RD, ZXUNO_DATA_PORT, 8'h00, id_byte);
      end
      add_op(OP_WR, ZXUNO_ADDR_PORT, REG_COREID, 8'h00);
      add_op(OP_RD, ZXUNO_DATA_PORT, 8'h00, COREID_STRING[id_len * 8 - 1 -: 8]);
      add_op(OP_RD, 16'hFE3B, 8'h00, FLOATING_BUS);
      add_op(OP_MEM, ZXUNO_DATA_PORT, 8'h00, FLOATING_BUS);
   endtask

   // Expected register state after a write
   task automatic track_write(input logic [15:0] port, input logic [7:0] data);
      if (port == ZXUNO_ADDR_PORT) begin
         trk_reg = data;
      end else if (port == ZXUNO_DATA_PORT) begin
         case (trk_reg)
            REG_DEVOPTIONS: exp_dev = data;
            REG_RASTERLINE: exp_raster.raster_line[7:0] = data;
            REG_RASTERCTRL: begin
               exp_raster.raster_line[8]      = data[0];
               exp_raster.rasterint_enable    = data[1];
               exp_raster.vretraceint_disable = data[2];
            end
            default: ;
         endcase
      end
   endtask

   // Two active cycles, then one idle
   task automatic apply_op(input op_t op);
      @(posedge cpuclkplain);
      io.addr                <= op.port;
      io.iorq_n              <= (op.kind == OP_MEM);
      io.rd_n                <= (op.kind == OP_WR);
      io.wr_n                <= (op.kind != OP_WR);
      cpu_dout               <= (op.kind == OP_WR) ? op.data : 8'h00;
      raster_int_in_progress <= (op.kind == OP_WR) ? 1'b0 : op.data[0];
      @(posedge cpuclkplain);
      @(negedge cpuclkplain);
      if (op.kind == OP_WR) begin
         track_write(op.port, op.data);
      end else begin
         check_value("cpu_din", 16'(op.exp), 16'(cpu_din));
      end
      @(posedge cpuclkplain);
      io.iorq_n <= 1'b1;
      io.rd_n   <= 1'b1;
      io.wr_n   <= 1'b1;
      @(negedge cpuclkplain);
      check_value("dev_options", 16'(exp_dev), 16'(dev_options));
      check_value("raster_cfg", 16'(exp_raster), 16'(raster_cfg));
   endtask

   initial begin
      void'($urandom(40962));
      io.addr                = 16'h0000;
      io.iorq_n              = 1'b1;
      io.rd_n                = 1'b1;
      io.wr_n                = 1'b1;
      cpu_dout               = 8'h00;
      raster_int_in_progress = 1'b0;
      rst_n                  = 1'b0;
      trk_reg                = 8'h00;
      exp_dev                = '0;
      exp_raster             = '0;
      build_ops();
      cycle_limit = 3 * ops.size() + 3 + 20;
      repeat (3) @(posedge cpuclkplain);
      rst_n <= 1'b1;
      foreach (ops[i]) begin
         apply_op(ops[i]);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
common/zxuno_pkg.sv
zxregs/zxuno_addr_port.sv
zxregs/coreid_reader.sv
zxregs/option_regs.sv
zxregs/rasterint_ctrl.sv
src/cpu_read_mux.sv
src/zxuno_core.sv
bench/zxuno_core_properties.sv
bench/zxuno_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module zxuno_core_tb -f src.f -o zxuno_core_sim

output=$(./obj_dir/zxuno_core_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^TEST PASS$"; then
   exit 0
else
   exit 1
fi
